//--- rv_pkg.sv
package rv_pkg;

  localparam int xlen = 64;
  localparam int nregs = 32;
  localparam logic [xlen-1:0] reset_pc = '0;

  // major opcodes
  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_auipc  = 7'b0010111;
  localparam logic [6:0] opc_jal    = 7'b1101111;
  localparam logic [6:0] opc_jalr   = 7'b1100111;
  localparam logic [6:0] opc_branch = 7'b1100011;
  localparam logic [6:0] opc_load   = 7'b0000011;
  localparam logic [6:0] opc_store  = 7'b0100011;
  localparam logic [6:0] opc_imm    = 7'b0010011;
  localparam logic [6:0] opc_imm32  = 7'b0011011;
  localparam logic [6:0] opc_reg    = 7'b0110011;
  localparam logic [6:0] opc_reg32  = 7'b0111011;
  localparam logic [6:0] opc_system = 7'b1110011;

  localparam logic [31:0] ebreak_word = 32'h0010_0073;

  typedef enum logic [5:0] {
    op_add, op_sub, op_and, op_or, op_xor, op_sll, op_srl, op_sra, op_slt, op_sltu,
    op_addw,
    op_addi, op_andi, op_ori, op_xori, op_slti, op_slli, op_srli, op_srai,
    op_addiw,
    op_lui, op_auipc,
    op_jal, op_jalr,
    op_beq, op_bne,
    op_ld, op_lw, op_lbu, op_sd, op_sh, op_sb,
    op_ebreak, op_illegal
  } op_e;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor,
    alu_sll, alu_srl, alu_sra, alu_slt, alu_sltu
  } alu_mode_e;

  typedef enum logic [1:0] {sz_byte, sz_half, sz_word, sz_double} mem_size_e;

  typedef enum logic [1:0] {s_fetch, s_exec, s_mem, s_halt} state_e;

  typedef struct packed {
    op_e             op;
    logic [4:0]      rd;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [xlen-1:0] imm;
    logic [5:0]      shamt;
  } decoded_t;

  typedef struct packed {
    logic            we;
    logic [xlen-1:0] addr;
    logic [xlen-1:0] wdata;
    logic [7:0]      sel;
    mem_size_e       size;
    logic            unsigned_ld;
  } mem_req_t;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [xlen-1:0] next_pc;
    logic [4:0]      rd;
    logic            wen;
    logic [xlen-1:0] wdata;
  } retire_t;

endpackage

//--- rv_decoder.sv
module rv_decoder
  import rv_pkg::*;
(
  input  logic [31:0] instr,
  output decoded_t    dec
);

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_s;
  logic [xlen-1:0] imm_b;
  logic [xlen-1:0] imm_u;
  logic [xlen-1:0] imm_j;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign imm_i = {{52{instr[31]}}, instr[31:20]};
  assign imm_s = {{52{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{51{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {{32{instr[31]}}, instr[31:12], 12'b0};
  assign imm_j = {{43{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    dec.rd    = instr[11:7];
    dec.rs1   = instr[19:15];
    dec.rs2   = instr[24:20];
    dec.shamt = instr[25:20];
    dec.imm   = imm_i;
    dec.op    = op_illegal;
    case (opcode)
      opc_reg: begin
        case ({funct7, funct3})
          10'b0000000_000: dec.op = op_add;
          10'b0100000_000: dec.op = op_sub;
          10'b0000000_111: dec.op = op_and;
          10'b0000000_110: dec.op = op_or;
          10'b0000000_100: dec.op = op_xor;
          10'b0000000_001: dec.op = op_sll;
          10'b0000000_101: dec.op = op_srl;
          10'b0100000_101: dec.op = op_sra;
          10'b0000000_010: dec.op = op_slt;
          10'b0000000_011: dec.op = op_sltu;
          default: dec.op = op_illegal;
        endcase
      end
      opc_reg32: if (funct7 == 7'b0 && funct3 == 3'b000) dec.op = op_addw;
      opc_imm: begin
        case (funct3)
          3'b000: dec.op = op_addi;
          3'b111: dec.op = op_andi;
          3'b110: dec.op = op_ori;
          3'b100: dec.op = op_xori;
          3'b010: dec.op = op_slti;
          3'b001: if (instr[31:26] == 6'b000000) dec.op = op_slli;
          // srli and srai differ only in funct6
          3'b101: begin
            if (instr[31:26] == 6'b000000) dec.op = op_srli;
            else if (instr[31:26] == 6'b010000) dec.op = op_srai;
          end
          default: dec.op = op_illegal;
        endcase
      end
      opc_imm32: if (funct3 == 3'b000) dec.op = op_addiw;
      opc_lui: begin
        dec.op  = op_lui;
        dec.imm = imm_u;
      end
      opc_auipc: begin
        dec.op  = op_auipc;
        dec.imm = imm_u;
      end
      opc_jal: begin
        dec.op  = op_jal;
        dec.imm = imm_j;
      end
      opc_jalr: if (funct3 == 3'b000) dec.op = op_jalr;
      opc_branch: begin
        dec.imm = imm_b;
        if (funct3 == 3'b000) dec.op = op_beq;
        else if (funct3 == 3'b001) dec.op = op_bne;
      end
      opc_load: begin
        if (funct3 == 3'b011) dec.op = op_ld;
        else if (funct3 == 3'b010) dec.op = op_lw;
        else if (funct3 == 3'b100) dec.op = op_lbu;
      end
      opc_store: begin
        dec.imm = imm_s;
        if (funct3 == 3'b011) dec.op = op_sd;
        else if (funct3 == 3'b001) dec.op = op_sh;
        else if (funct3 == 3'b000) dec.op = op_sb;
      end
      opc_system: if (instr == ebreak_word) dec.op = op_ebreak;
      default: dec.op = op_illegal;
    endcase
  end

endmodule

//--- rv_regfile.sv
module rv_regfile
  import rv_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  input  logic [4:0]      raddr1,
  input  logic [4:0]      raddr2,
  output logic [xlen-1:0] rdata1,
  output logic [xlen-1:0] rdata2,
  input  logic [4:0]      waddr,
  input  logic [xlen-1:0] wdata,
  input  logic            we
);

  logic [xlen-1:0] regs [nregs];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < nregs; i++) begin
        regs[i] <= '0;
      end
    end else if (we && waddr != 5'd0) begin
      // x0 never written, so it reads back zero
      regs[waddr] <= wdata;
    end
  end

  assign rdata1 = regs[raddr1];
  assign rdata2 = regs[raddr2];

endmodule

//--- rv_alu.sv
module rv_alu
  import rv_pkg::*;
(
  input  alu_mode_e       mode,
  input  logic [xlen-1:0] a,
  input  logic [xlen-1:0] b,
  output logic [xlen-1:0] result
);

  logic [5:0] sh;

  // rv64 shift amount
  assign sh = b[5:0];

  always_comb begin
    case (mode)
      alu_add: result = a + b;
      alu_sub: result = a - b;
      alu_and: result = a & b;
      alu_or:  result = a | b;
      alu_xor: result = a ^ b;
      alu_sll: result = a << sh;
      alu_srl: result = a >> sh;
      alu_sra: result = $signed(a) >>> sh;
      alu_slt: result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
      alu_sltu: result = {{(xlen-1){1'b0}}, a < b};
      default: result = a + b;
    endcase
  end

endmodule

//--- rv_exu.sv
module rv_exu
  import rv_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  input  decoded_t        dec,
  input  logic [xlen-1:0] pc,
  input  logic            commit,
  input  logic [xlen-1:0] ld_data,
  output mem_req_t        req,
  output logic            is_mem,
  output logic [xlen-1:0] next_pc,
  output retire_t         retire,
  output logic            a0_zero
);

  logic [4:0]      raddr1;
  logic [xlen-1:0] src1;
  logic [xlen-1:0] src2;
  logic [xlen-1:0] op_a;
  logic [xlen-1:0] op_b;
  logic [xlen-1:0] alu_res;
  logic [xlen-1:0] pc_plus4;
  logic [xlen-1:0] wb_data;
  alu_mode_e       mode;
  logic            use_rs2;
  logic            use_pc;
  logic            shift_imm;
  logic            is_load;
  logic            is_store;
  logic            is_w;
  logic            wen;
  logic            taken;

  // ebreak reads a0 through port 1 for the exit status
  assign raddr1 = (dec.op == op_ebreak) ? 5'd10 : dec.rs1;

  rv_regfile u_regfile (
    .clk    (clk),
    .rst_n  (rst_n),
    .raddr1 (raddr1),
    .raddr2 (dec.rs2),
    .rdata1 (src1),
    .rdata2 (src2),
    .waddr  (dec.rd),
    .wdata  (wb_data),
    .we     (commit & wen)
  );

  assign use_rs2 = dec.op inside {op_add, op_sub, op_and, op_or, op_xor, op_sll, op_srl,
                                  op_sra, op_slt, op_sltu, op_addw, op_beq, op_bne};
  assign use_pc    = dec.op inside {op_auipc, op_jal};
  assign shift_imm = dec.op inside {op_slli, op_srli, op_srai};
  assign is_load   = dec.op inside {op_ld, op_lw, op_lbu};
  assign is_store  = dec.op inside {op_sd, op_sh, op_sb};
  assign is_w      = dec.op inside {op_addw, op_addiw};

  assign op_a = use_pc ? pc : src1;
  assign op_b = use_rs2 ? src2 : (shift_imm ? {{(xlen-6){1'b0}}, dec.shamt} : dec.imm);

  always_comb begin
    case (dec.op)
      op_sub, op_beq, op_bne: mode = alu_sub;
      op_and, op_andi:        mode = alu_and;
      op_or, op_ori:          mode = alu_or;
      op_xor, op_xori:        mode = alu_xor;
      op_sll, op_slli:        mode = alu_sll;
      op_srl, op_srli:        mode = alu_srl;
      op_sra, op_srai:        mode = alu_sra;
      op_slt, op_slti:        mode = alu_slt;
      op_sltu:                mode = alu_sltu;
      default:                mode = alu_add;
    endcase
  end

  rv_alu u_alu (
    .mode   (mode),
    .a      (op_a),
    .b      (op_b),
    .result (alu_res)
  );

  assign pc_plus4 = pc + 64'd4;
  // branches compare through the subtractor
  assign taken = (dec.op == op_beq && alu_res == '0) || (dec.op == op_bne && alu_res != '0);

  always_comb begin
    next_pc = pc_plus4;
    if (dec.op == op_jal) next_pc = alu_res;
    else if (dec.op == op_jalr) next_pc = {alu_res[xlen-1:1], 1'b0};
    else if (taken) next_pc = pc + dec.imm;
  end

  always_comb begin
    if (dec.op == op_lui) wb_data = dec.imm;
    else if (dec.op inside {op_jal, op_jalr}) wb_data = pc_plus4;
    else if (is_load) wb_data = ld_data;
    else if (is_w) wb_data = {{32{alu_res[31]}}, alu_res[31:0]};
    else wb_data = alu_res;
  end

  assign wen = !(is_store || dec.op inside {op_beq, op_bne, op_ebreak, op_illegal});

  always_comb begin
    req.we          = is_store;
    req.addr        = alu_res;
    req.wdata       = src2;
    req.sel         = '0;
    req.unsigned_ld = (dec.op == op_lbu);
    case (dec.op)
      op_ld, op_sd: req.size = sz_double;
      op_lw:        req.size = sz_word;
      op_sh:        req.size = sz_half;
      default:      req.size = sz_byte;
    endcase
  end

  assign is_mem = is_load | is_store;

  assign retire.pc      = pc;
  assign retire.next_pc = next_pc;
  assign retire.rd      = dec.rd;
  assign retire.wen     = wen;
  assign retire.wdata   = wb_data;

  // only meaningful while an ebreak is decoded
  assign a0_zero = (src1 == '0);

endmodule

//--- rv_lsu.sv
module rv_lsu
  import rv_pkg::*;
(
  input  mem_req_t        raw,
  output mem_req_t        bus_req,
  input  logic [xlen-1:0] bus_rdata,
  output logic [xlen-1:0] ld_data
);

  logic [2:0]      lane;
  logic [5:0]      lane_shift;
  logic [7:0]      size_sel;
  logic [xlen-1:0] size_mask;
  logic [xlen-1:0] lane_data;

  assign lane       = raw.addr[2:0];
  assign lane_shift = {lane, 3'b000};

  always_comb begin
    case (raw.size)
      sz_byte: begin
        size_sel  = 8'h01;
        size_mask = 64'h0000_0000_0000_00ff;
      end
      sz_half: begin
        size_sel  = 8'h03;
        size_mask = 64'h0000_0000_0000_ffff;
      end
      sz_word: begin
        size_sel  = 8'h0f;
        size_mask = 64'h0000_0000_ffff_ffff;
      end
      default: begin
        size_sel  = 8'hff;
        size_mask = '1;
      end
    endcase
  end

  // a halfword crossing the doubleword loses its upper lane
  always_comb begin
    bus_req       = raw;
    bus_req.wdata = (raw.wdata & size_mask) << lane_shift;
    bus_req.sel   = size_sel << lane;
  end

  assign lane_data = bus_rdata >> lane_shift;

  always_comb begin
    case (raw.size)
      sz_byte: begin
        if (raw.unsigned_ld) ld_data = {56'b0, lane_data[7:0]};
        else ld_data = {{56{lane_data[7]}}, lane_data[7:0]};
      end
      sz_half: begin
        if (raw.unsigned_ld) ld_data = {48'b0, lane_data[15:0]};
        else ld_data = {{48{lane_data[15]}}, lane_data[15:0]};
      end
      sz_word: begin
        if (raw.unsigned_ld) ld_data = {32'b0, lane_data[31:0]};
        else ld_data = {{32{lane_data[31]}}, lane_data[31:0]};
      end
      default: ld_data = lane_data;
    endcase
  end

endmodule

//--- rv_core.sv
module rv_core
  import rv_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  output logic            wb_cyc,
  output logic            wb_stb,
  output logic            wb_we,
  output logic [xlen-1:0] wb_adr,
  output logic [xlen-1:0] wb_dat_o,
  output logic [7:0]      wb_sel,
  input  logic [xlen-1:0] wb_dat_i,
  input  logic            wb_ack,
  output logic            retire_valid,
  output retire_t         retire,
  output logic            halted,
  output logic            halt_fail,
  output logic            illegal
);

  state_e          state;
  logic [xlen-1:0] pc;
  logic [xlen-1:0] next_pc;
  logic [xlen-1:0] ld_data;
  logic [31:0]     ir;
  decoded_t        dec;
  mem_req_t        raw_req;
  mem_req_t        bus_req;
  logic            is_mem;
  logic            a0_zero;
  logic            done;
  logic            stop;
  logic            commit;

  rv_decoder u_decoder (.instr(ir), .dec(dec));

  rv_exu u_exu (
    .clk     (clk),
    .rst_n   (rst_n),
    .dec     (dec),
    .pc      (pc),
    .commit  (commit),
    .ld_data (ld_data),
    .req     (raw_req),
    .is_mem  (is_mem),
    .next_pc (next_pc),
    .retire  (retire),
    .a0_zero (a0_zero)
  );

  rv_lsu u_lsu (.raw(raw_req), .bus_req(bus_req), .bus_rdata(wb_dat_i), .ld_data(ld_data));

  assign done   = wb_cyc & wb_ack;
  assign stop   = dec.op inside {op_ebreak, op_illegal};
  assign commit = (state == s_exec && !is_mem) || (state == s_mem && done);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= s_fetch;
      pc        <= reset_pc;
      halt_fail <= 1'b0;
      illegal   <= 1'b0;
    end else begin
      case (state)
        s_fetch: if (done) state <= s_exec;
        s_exec: begin
          if (stop) begin
            state     <= s_halt;
            halt_fail <= (dec.op == op_ebreak) && !a0_zero;
            illegal   <= (dec.op == op_illegal);
          end else if (is_mem) begin
            state <= s_mem;
          end else begin
            pc    <= next_pc;
            state <= s_fetch;
          end
        end
        s_mem: begin
          if (done) begin
            pc    <= next_pc;
            state <= s_fetch;
          end
        end
        default: state <= s_halt;
      endcase
    end
  end

  // upper or lower word of the fetched doubleword
  always_ff @(posedge clk) begin
    if (state == s_fetch && done) ir <= pc[2] ? wb_dat_i[63:32] : wb_dat_i[31:0];
  end

  // cycle opens one clock after entering fetch or mem, closes after ack
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) wb_cyc <= 1'b0;
    else if (done) wb_cyc <= 1'b0;
    else if (state == s_fetch || state == s_mem) wb_cyc <= 1'b1;
  end

  assign wb_stb   = wb_cyc;
  assign wb_we    = (state == s_mem) && bus_req.we;
  assign wb_adr   = (state == s_mem) ? bus_req.addr : pc;
  assign wb_dat_o = bus_req.wdata;
  assign wb_sel   = (state == s_mem) ? bus_req.sel : 8'hff;

  assign retire_valid = commit;
  assign halted       = (state == s_halt);

endmodule

//--- tb_core_properties.sv
module tb_core_properties
  import rv_pkg::*;
(
  input logic            clk,
  input logic            rst_n,
  input logic            wb_cyc,
  input logic            wb_stb,
  input logic            wb_we,
  input logic [xlen-1:0] wb_adr,
  input logic [xlen-1:0] wb_dat_o,
  input logic [7:0]      wb_sel,
  input logic            wb_ack,
  input logic            retire_valid,
  input logic            halted
);

  a_stb_cyc: assert property (@(posedge clk) disable iff (!rst_n) wb_stb |-> wb_cyc)
    else $error("stb without cyc");

  // request held until the slave acks
  a_stable: assert property (@(posedge clk) disable iff (!rst_n)
    wb_cyc && !wb_ack |=> wb_cyc && $stable({wb_we, wb_adr, wb_dat_o, wb_sel}))
    else $error("request changed while waiting for ack");

  // halt is sticky until reset
  a_no_retire_halted: assert property (@(posedge clk) disable iff (!rst_n)
    halted |=> halted && !retire_valid)
    else $error("retire or halt dropped while halted");

  a_cyc_reset: assert property (@(posedge clk) !rst_n |-> !wb_cyc)
    else $error("cyc high during reset");

endmodule

bind rv_core tb_core_properties props0 (
  .clk          (clk),
  .rst_n        (rst_n),
  .wb_cyc       (wb_cyc),
  .wb_stb       (wb_stb),
  .wb_we        (wb_we),
  .wb_adr       (wb_adr),
  .wb_dat_o     (wb_dat_o),
  .wb_sel       (wb_sel),
  .wb_ack       (wb_ack),
  .retire_valid (retire_valid),
  .halted       (halted)
);

//--- tb_core.sv
module tb_core
  import rv_pkg::*;
();

  localparam int n_instr = 200;
  localparam int max_cycles = (n_instr + 1) * 12 + 60;

  logic            clk;
  logic            rst_n;
  logic            wb_cyc;
  logic            wb_stb;
  logic            wb_we;
  logic [xlen-1:0] wb_adr;
  logic [xlen-1:0] wb_dat_o;
  logic [7:0]      wb_sel;
  logic [xlen-1:0] wb_dat_i;
  logic            wb_ack;
  logic            retire_valid;
  retire_t         retire;
  logic            halted;
  logic            halt_fail;
  logic            illegal;

  // 8 KiB shared space, program at 0, data from 0x1000
  logic [63:0] mem [1024];
  logic [63:0] mmem [1024];
  logic [63:0] mreg [32];
  logic [63:0] mpc;

  op_e         p_op [n_instr];
  logic [63:0] p_imm [n_instr];
  logic [4:0]  p_rs1 [n_instr];
  logic [4:0]  p_rs2 [n_instr];
  logic [31:0] p_word [n_instr];

  // register ops and their {funct7, funct3}
  op_e        r_ops [11] = '{op_add, op_sub, op_and, op_or, op_xor, op_sll, op_srl,
                             op_sra, op_slt, op_sltu, op_addw};
  logic [9:0] r_fn [11] = '{10'h000, 10'h100, 10'h007, 10'h006, 10'h004, 10'h001,
                            10'h005, 10'h105, 10'h002, 10'h003, 10'h000};
  op_e        i_ops [9] = '{op_addi, op_andi, op_ori, op_xori, op_slti, op_slli, op_srli,
                            op_srai, op_addiw};
  logic [2:0] i_f3 [9] = '{3'd0, 3'd7, 3'd6, 3'd4, 3'd2, 3'd1, 3'd5, 3'd5, 3'd0};
  op_e        m_ops [6] = '{op_ld, op_lw, op_lbu, op_sd, op_sh, op_sb};
  logic [2:0] m_f3 [6] = '{3'd3, 3'd2, 3'd4, 3'd3, 3'd1, 3'd0};
  int         m_align [6] = '{8, 4, 1, 8, 2, 1};

  int       errors;
  int       wait_n;
  int       run2_retires;
  logic     busy;
  logic     illegal_run;
  logic     fetch_pending;
  logic     wr_seen;
  mem_req_t exp_fetch;
  mem_req_t got_wr;

  rv_core dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3, logic [4:0] rd, logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                        logic [4:0] rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], opc_store};
  endfunction

  function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch};
  endfunction

  function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal};
  endfunction

  task automatic check_retire(input retire_t got, input retire_t exp, input string what);
    if (!exp.wen) exp.wdata = got.wdata;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED t=%0t %s: got pc %h npc %h rd %0d wen %b data %h", $time, what,
               got.pc, got.next_pc, got.rd, got.wen, got.wdata);
      $display("  expected pc %h npc %h rd %0d wen %b data %h", exp.pc, exp.next_pc, exp.rd,
               exp.wen, exp.wdata);
    end
  endtask

  task automatic check_req(input mem_req_t got, input mem_req_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED t=%0t %s: got we %b adr %h dat %h sel %h", $time, what, got.we,
               got.addr, got.wdata, got.sel);
      $display("  expected we %b adr %h dat %h sel %h", exp.we, exp.addr, exp.wdata, exp.sel);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED t=%0t %s: got %b exp %b", $time, what, got, exp);
    end
  endtask

  task automatic gen_slot(input int k);
    int          cat;
    int          i;
    int          tgt;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] i12;
    logic [5:0]  sh;
    logic [19:0] u;
    logic [63:0] off;
    rd  = 5'($urandom % 31);
    rs1 = 5'($urandom % 32);
    rs2 = 5'($urandom % 32);
    cat = $urandom % 10;
    tgt = k + 1 + ($urandom % 4);
    if (tgt > n_instr - 1) tgt = n_instr - 1;
    p_imm[k] = '0;
    if (cat < 3) begin
      i = $urandom % 11;
      p_op[k] = r_ops[i];
      p_word[k] = enc_r(r_fn[i][9:3], rs2, rs1, r_fn[i][2:0], rd,
                        (i == 10) ? opc_reg32 : opc_reg);
    end else if (cat < 5) begin
      i = $urandom % 9;
      i12 = 12'($urandom);
      p_imm[k] = {{52{i12[11]}}, i12};
      if (i >= 5 && i <= 7) begin
        sh = 6'($urandom % 64);
        i12 = {(i == 7) ? 6'b010000 : 6'b000000, sh};
        p_imm[k] = {58'b0, sh};
      end
      p_op[k] = i_ops[i];
      p_word[k] = enc_i(i12, rs1, i_f3[i], rd, (i == 8) ? opc_imm32 : opc_imm);
    end else if (cat == 5) begin
      u = 20'($urandom);
      p_imm[k] = {{32{u[19]}}, u, 12'b0};
      p_op[k] = ($urandom % 2 == 0) ? op_lui : op_auipc;
      p_word[k] = {u, rd, (p_op[k] == op_lui) ? opc_lui : opc_auipc};
    end else if (cat == 6) begin
      if ($urandom % 2 == 0) begin
        p_op[k] = op_jal;
        p_imm[k] = 64'((tgt - k) * 4);
        p_word[k] = enc_j(p_imm[k][20:0], rd);
      end else begin
        // absolute target through x0
        rs1 = 5'd0;
        p_op[k] = op_jalr;
        p_imm[k] = 64'(tgt * 4);
        p_word[k] = enc_i(p_imm[k][11:0], rs1, 3'd0, rd, opc_jalr);
      end
    end else if (cat == 7) begin
      if ($urandom % 2 == 0) rs2 = rs1;
      p_op[k] = ($urandom % 2 == 0) ? op_beq : op_bne;
      p_imm[k] = 64'((tgt - k) * 4);
      p_word[k] = enc_b(p_imm[k][12:0], rs2, rs1, (p_op[k] == op_beq) ? 3'd0 : 3'd1);
    end else begin
      i = $urandom % 6;
      rs1 = 5'd31;
      off = 64'($urandom % 2048) & ~64'(m_align[i] - 1);
      p_op[k] = m_ops[i];
      p_imm[k] = off;
      if (i < 3) p_word[k] = enc_i(off[11:0], rs1, m_f3[i], rd, opc_load);
      else p_word[k] = enc_s(off[11:0], rs2, rs1, m_f3[i]);
    end
    p_rs1[k] = rs1;
    p_rs2[k] = rs2;
  endtask

  task automatic build_program();
    for (int i = 0; i < 1024; i++) begin
      mem[i] = {32'(i) * 32'h9e37_79b9, ~32'(i)};
    end
    // x31 is the data base, 0x1000
    p_op[0] = op_lui;
    p_imm[0] = 64'h1000;
    p_rs1[0] = 5'd0;
    p_rs2[0] = 5'd0;
    p_word[0] = {20'h00001, 5'd31, opc_lui};
    for (int k = 1; k < n_instr - 1; k++) begin
      gen_slot(k);
    end
    p_op[n_instr-1] = op_ebreak;
    p_word[n_instr-1] = ebreak_word;
    p_rs1[n_instr-1] = 5'd0;
    p_rs2[n_instr-1] = 5'd0;
    p_imm[n_instr-1] = '0;
    for (int k = 0; k < n_instr; k++) begin
      mem[k/2][32*(k%2) +: 32] = p_word[k];
    end
    mmem = mem;
  endtask

  task automatic model_step(input retire_t got);
    int          k;
    op_e         op;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] imm;
    logic [63:0] v;
    logic [63:0] t;
    logic [63:0] addr;
    logic [63:0] dw;
    logic [63:0] mask;
    logic [7:0]  sel;
    retire_t     exp;
    mem_req_t    exp_wr;
    k = int'(mpc >> 2);
    op = p_op[k];
    imm = p_imm[k];
    a = mreg[p_rs1[k]];
    b = mreg[p_rs2[k]];
    if (op inside {op_addi, op_andi, op_ori, op_xori, op_slti, op_slli, op_srli, op_srai,
                   op_addiw}) b = imm;
    addr = a + imm;
    dw = mmem[addr[12:3]] >> {addr[2:0], 3'b000};
    exp.pc = mpc;
    exp.next_pc = mpc + 64'd4;
    exp.rd = p_word[k][11:7];
    exp.wen = 1'b1;
    v = '0;
    mask = '0;
    sel = '0;
    case (op)
      op_add, op_addi: v = a + b;
      op_sub: v = a - b;
      op_and, op_andi: v = a & b;
      op_or, op_ori: v = a | b;
      op_xor, op_xori: v = a ^ b;
      op_sll, op_slli: v = a << b[5:0];
      op_srl, op_srli: v = a >> b[5:0];
      op_sra, op_srai: v = $signed(a) >>> b[5:0];
      op_slt, op_slti: v = {63'b0, $signed(a) < $signed(b)};
      op_sltu: v = {63'b0, a < b};
      op_addw, op_addiw: begin
        t = a + b;
        v = {{32{t[31]}}, t[31:0]};
      end
      op_lui: v = imm;
      op_auipc: v = mpc + imm;
      op_jal: begin
        v = mpc + 64'd4;
        exp.next_pc = mpc + imm;
      end
      op_jalr: begin
        v = mpc + 64'd4;
        exp.next_pc = addr & ~64'd1;
      end
      op_beq, op_bne: begin
        exp.wen = 1'b0;
        if ((a == b) == (op == op_beq)) exp.next_pc = mpc + imm;
      end
      op_ld: v = dw;
      op_lw: v = {{32{dw[31]}}, dw[31:0]};
      op_lbu: v = {56'b0, dw[7:0]};
      op_sd: mask = '1;
      op_sh: mask = 64'hffff;
      op_sb: mask = 64'hff;
      default: exp.wen = 1'b0;
    endcase
    if (op inside {op_sd, op_sh, op_sb}) begin
      exp.wen = 1'b0;
      sel = (op == op_sd) ? 8'hff : ((op == op_sh) ? 8'h03 : 8'h01);
      exp_wr = '{we: 1'b1, addr: addr, wdata: (b & mask) << {addr[2:0], 3'b000},
                 sel: sel << addr[2:0], size: sz_byte, unsigned_ld: 1'b0};
      check_bit(wr_seen, 1'b1, "store seen on bus");
      check_req(got_wr, exp_wr, "store request");
      wr_seen = 1'b0;
      for (int i = 0; i < 8; i++) begin
        if (exp_wr.sel[i]) mmem[addr[12:3]][8*i +: 8] = exp_wr.wdata[8*i +: 8];
      end
    end
    if (exp.wen && exp.rd != 5'd0) mreg[exp.rd] = v;
    exp.wdata = v;
    check_retire(got, exp, "retire");
    mpc = exp.next_pc;
    exp_fetch.addr = mpc;
    fetch_pending = (op != op_ebreak);
  endtask

  // retire record is stable by the falling edge
  always @(negedge clk) begin
    if (rst_n && retire_valid) begin
      if (illegal_run) begin
        run2_retires++;
        check_bit(retire.wen, 1'b0, "illegal retire wen");
        check_bit(retire.pc == reset_pc, 1'b1, "illegal retire pc");
      end else begin
        model_step(retire);
      end
    end
  end

  // wishbone slave with 0 to 3 wait cycles
  always @(posedge clk) begin
    mem_req_t cur;
    #1;
    if (!rst_n) begin
      wb_ack = 1'b0;
      busy = 1'b0;
    end else if (wb_ack) begin
      wb_ack = 1'b0;
    end else if (wb_cyc && wb_stb) begin
      if (!busy) begin
        busy = 1'b1;
        wait_n = $urandom % 4;
        cur = '{we: wb_we, addr: wb_adr, wdata: wb_we ? wb_dat_o : '0, sel: wb_sel,
                size: sz_byte, unsigned_ld: 1'b0};
        if (fetch_pending && !wb_we) begin
          check_req(cur, exp_fetch, "fetch address");
          fetch_pending = 1'b0;
        end else if (wb_we) begin
          got_wr = cur;
          wr_seen = 1'b1;
        end
      end
      if (wait_n == 0) begin
        if (wb_we) begin
          for (int i = 0; i < 8; i++) begin
            if (wb_sel[i]) mem[wb_adr[12:3]][8*i +: 8] = wb_dat_o[8*i +: 8];
          end
        end else begin
          wb_dat_i = mem[wb_adr[12:3]];
        end
        wb_ack = 1'b1;
        busy = 1'b0;
      end else begin
        wait_n--;
      end
    end
  end

  task automatic reset_dut();
    rst_n = 1'b0;
    for (int i = 0; i < 32; i++) begin
      mreg[i] = '0;
    end
    mpc = reset_pc;
    exp_fetch = '{we: 1'b0, addr: reset_pc, wdata: '0, sel: 8'hff, size: sz_byte,
                  unsigned_ld: 1'b0};
    fetch_pending = 1'b1;
    wr_seen = 1'b0;
    repeat (2) @(posedge clk);
    #1 rst_n = 1'b1;
  endtask

  task automatic wait_halt();
    @(posedge clk);
    while (!halted) @(posedge clk);
    #1;
  endtask

  initial begin
    #(max_cycles * 4);
    $display("timeout: core did not halt within %0d cycles", max_cycles);
    $display("Test failed");
    $finish;
  end

  initial begin
    logic [6:0] bad_opc [4];
    logic [31:0] w;
    bad_opc = '{7'b0001111, 7'b0101111, 7'b1010011, 7'b0000111};
    void'($urandom(32'h7fdf_69f8));
    rst_n = 1'b0;
    wb_ack = 1'b0;
    wb_dat_i = '0;
    errors = 0;
    run2_retires = 0;
    busy = 1'b0;
    illegal_run = 1'b0;
    build_program();
    reset_dut();
    wait_halt();
    check_bit(halt_fail, mreg[10] != 64'd0, "halt_fail");
    check_bit(illegal, 1'b0, "illegal after ebreak");
    check_bit(mpc == 64'(n_instr * 4), 1'b1, "reached final ebreak");

    // second run, a single word outside the subset
    w = $urandom;
    w[6:0] = bad_opc[$urandom % 4];
    mem[0] = {32'h0, w};
    illegal_run = 1'b1;
    reset_dut();
    wait_halt();
    check_bit(illegal, 1'b1, "illegal flag");
    check_bit(halt_fail, 1'b0, "halt_fail on illegal");
    check_bit(run2_retires == 1, 1'b1, "one retire before illegal halt");

    $display("summary: %0d errors", errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- sim.f
rv_pkg.sv
rv_decoder.sv
rv_regfile.sv
rv_alu.sv
rv_exu.sv
rv_lsu.sv
rv_core.sv
tb_core_properties.sv
tb_core.sv

//--- Makefile
TOP = tb_core

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f sim.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -qx "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: help test clean
